// ==== capture_input.txt ====
# columns: pattern_base drain_mode expected_bytes expected_overflow
# drain_mode 0 drain on, 1 random gaps, 2 drain after frame_done, 3 two frames back to back
0 0 16 0
1 0 16 0
2 0 16 0
3 0 16 0
# short drain gaps
0 1 16 0
1 1 16 0
2 1 16 0
3 1 16 0
# drain held off, then a normal frame clears overflow
0 2 4 1
0 0 16 0
3 2 4 1
3 0 16 0
2 2 4 1
2 1 16 0
# capture_enable held over two frames
0 3 32 0
1 3 32 0
3 2 4 1
3 3 32 0
2 3 32 0
1 0 16 0

// ==== compile.f ====
capture_timing_pkg.sv
pixel_pkg.sv
sync_timing_gen.sv
line_fifo.sv
pixel_packer.sv
capture_top.sv
capture_assert.sv
tb_capture.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_capture \
  -f compile.f -o tb_capture_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_capture_sim +verilator+error+limit+100)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation finished: PASS" && echo "run passed" \
  || { echo "run failed"; exit 1; }

// ==== tb_capture.sv ====
`timescale 1ns/1ps

module tb_capture;
  import capture_timing_pkg::*;
  import pixel_pkg::*;

  // drain behavior of one test
  typedef enum logic [1:0] {
    DRAIN_ON,  // drain high for the whole frame
    DRAIN_GAPS,  // short random gaps in the drain
    DRAIN_LATE,  // drain off until frame_done
    BACK_TO_BACK  // two frames in a row, drain high
  } drain_mode_t;

  // one record of capture_input.txt
  typedef struct packed {
    pixel_t      base;
    drain_mode_t mode;
    logic [7:0]  byte_count;  // bytes expected from the whole test
    logic        expect_overflow;  // overflow level at the last frame_done
  } test_record_t;

  logic   clock;
  logic   reset;
  logic   capture_enable;
  pixel_t pattern_base;
  logic   drain_enable;
  byte_t  pixel_byte;
  logic   byte_valid;
  logic   frame_done;
  logic   overflow;
  logic   fifo_empty;

  test_record_t records[$];
  byte_t        got_bytes[$];  // bytes of the running test, in arrival order
  int           frames_seen = 0;
  logic         done_overflow = 1'b0;  // overflow taken with the latest frame_done
  logic         empty_seen = 1'b1;
  logic         records_loaded = 1'b0;
  int           error_count = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;
  int           seed = 47390;

  capture_top DUT (
    .clock          (clock),
    .reset          (reset),
    .capture_enable (capture_enable),
    .pattern_base   (pattern_base),
    .drain_enable   (drain_enable),
    .pixel_byte     (pixel_byte),
    .byte_valid     (byte_valid),
    .frame_done     (frame_done),
    .overflow       (overflow),
    .fifo_empty     (fifo_empty)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  // outputs taken mid-cycle, main flow reads these copies on the rising edge
  always @(negedge clock)
  begin
    if (!reset)
    begin
      if (byte_valid)
        got_bytes.push_back(pixel_byte);
      if (frame_done)
      begin
        frames_seen = frames_seen + 1;
        done_overflow = overflow;
      end
      empty_seen = fifo_empty;
    end
  end

  // pixel (c + l + base) mod 4, four per byte, first pixel in the low bits
  function automatic byte_t expected_byte(input pixel_t base, input int index);
    byte_t value;
    int    frame_index;  // byte position inside its own frame
    int    line_index;
    int    first_column;
    int    k;
    frame_index = index % (ACTIVE_LINES * ACTIVE_PIXELS / PIXELS_PER_BYTE);
    line_index = frame_index / (ACTIVE_PIXELS / PIXELS_PER_BYTE);
    first_column = (frame_index % (ACTIVE_PIXELS / PIXELS_PER_BYTE)) * PIXELS_PER_BYTE;
    value = '0;
    for (k = 0; k < PIXELS_PER_BYTE; k++)
      value[$bits(pixel_t)*k +: $bits(pixel_t)] =
        pixel_t'(first_column + k + line_index + int'(base));
    return value;
  endfunction

  task automatic compare_byte(input byte_t got, input byte_t expected, input int index);
    if (got !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t: byte %0d is %h, expected %h", $time, index, got, expected);
    end
  endtask

  task automatic compare_overflow(input logic got, input logic expected, input string what);
    if (got !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic compare_empty(input logic got, input logic expected, input string what);
    if (got !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic compare_count(input int got, input int expected, input string what);
    if (got != expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // lines starting with # are notes, other lines hold base, mode, bytes, overflow
  task automatic read_records();
    int           fd;
    string        text;
    int           base_value;
    int           mode_value;
    int           count_value;
    int           overflow_value;
    test_record_t rec;
    fd = $fopen("capture_input.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        text = "";
        void'($fgets(text, fd));
        if (text.len() > 0 && text.getc(0) != "#" &&
            $sscanf(text, "%d %d %d %d", base_value, mode_value, count_value,
                    overflow_value) == 4)
        begin
          rec.base = pixel_t'(base_value);
          rec.mode = drain_mode_t'(mode_value[1:0]);
          rec.byte_count = count_value[7:0];
          rec.expect_overflow = (overflow_value != 0);
          records.push_back(rec);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int number, input test_record_t rec);
    int   start_errors;
    int   start_frames;
    int   frame_total;
    int   expected_total;
    int   drain_left;  // clocks left in the current drain phase
    logic drain_on;
    int   idx;
    start_errors = error_count;
    start_frames = frames_seen;
    frame_total = (rec.mode == BACK_TO_BACK) ? 2 : 1;
    expected_total = int'(rec.byte_count);
    got_bytes.delete();
    @(posedge clock);
    pattern_base <= rec.base;
    drain_enable <= (rec.mode != DRAIN_LATE);
    capture_enable <= 1'b1;  // generator leaves IDLE on the next edge
    @(posedge clock);
    if (rec.mode != BACK_TO_BACK)
      capture_enable <= 1'b0;
    if (rec.mode == BACK_TO_BACK)
    begin
      while (frames_seen < start_frames + 1)
        @(posedge clock);
      capture_enable <= 1'b0;  // still high when the first frame ends, so frame two runs
    end
    drain_on = 1'b1;
    drain_left = 5 + ($unsigned($random(seed)) % 4);
    while (frames_seen < start_frames + frame_total)
    begin
      @(posedge clock);
      if (rec.mode == DRAIN_GAPS && drain_left == 0)
      begin
        drain_on = ~drain_on;
        if (drain_on)
          drain_left = 5 + ($unsigned($random(seed)) % 4);  // 5..8 clocks on
        else
          drain_left = 1 + ($unsigned($random(seed)) % 2);  // 1..2 clocks off
        drain_enable <= drain_on;
      end
      drain_left = drain_left - 1;
    end
    drain_enable <= 1'b1;  // empty whatever is left in the FIFO
    while (got_bytes.size() < expected_total || !empty_seen)
      @(posedge clock);
    compare_count(got_bytes.size(), expected_total, "byte count");
    for (idx = 0; idx < got_bytes.size() && idx < expected_total; idx++)
      compare_byte(got_bytes[idx], expected_byte(rec.base, idx), idx);
    compare_overflow(done_overflow, rec.expect_overflow, "overflow at frame_done");
    compare_count(frames_seen - start_frames, frame_total, "frame_done pulses");
    if (error_count == start_errors)
      tests_passed = tests_passed + 1;
    else
      tests_failed = tests_failed + 1;
    $display("test %0d base %0d %s: %s, %0d bytes", number, rec.base, rec.mode.name(),
             (error_count == start_errors) ? "passed" : "failed", got_bytes.size());
  endtask

  // four frame lengths per record covers every drain mode
  initial
  begin
    wait (records_loaded);
    repeat (records.size() * 4 * FRAME_CLOCKS) @(posedge clock);
    $display("timeout: tests still running after %0d frame lengths", records.size() * 4);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    reset = 1'b1;
    capture_enable = 1'b0;
    pattern_base = '0;
    drain_enable = 1'b1;
    read_records();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    if (records.size() == 0)
    begin
      $display("no test records could be read from capture_input.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end
    else
    begin
      records_loaded = 1'b1;
      @(posedge clock);
      compare_empty(empty_seen, 1'b1, "fifo_empty after reset");  // FIFO starts with no pixels
      foreach (records[i])
        run_test(i, records[i]);
      $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
               records.size(), tests_passed, tests_failed, error_count,
               DUT.u_fifo.u_assert.failure_count);
      if (tests_failed == 0 && error_count == 0 && DUT.u_fifo.u_assert.failure_count == 0)
        $display("Simulation finished: PASS");
      else
        $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// ==== capture_assert.sv ====
`timescale 1ns/1ps

module capture_assert (
  input logic clock,
  input logic reset,
  input logic rd,  // read strobe seen by the FIFO
  input logic empty,
  input logic full
);
  int failure_count = 0;  // failed checks so far

  // count steps by one, a read and a write together leave it, so full needs a lone write
  full_rises_without_read: assert property (@(posedge clock) disable iff (reset)
    $rose(full) |-> !$past(rd))
  else
  begin
    failure_count = failure_count + 1;
    $error("FIFO went full on a clock with a read");
  end

  // the last pixel only leaves through a read
  empty_rises_after_read: assert property (@(posedge clock) disable iff (reset)
    $rose(empty) |-> $past(rd))
  else
  begin
    failure_count = failure_count + 1;
    $error("FIFO went empty without a read");
  end

  // packer forms rd from empty, so a read never meets an empty FIFO
  no_read_when_empty: assert property (@(posedge clock) disable iff (reset) rd |-> !empty)
  else
  begin
    failure_count = failure_count + 1;
    $error("read strobe while the FIFO is empty");
  end

  // nothing is written during reset
  empty_after_reset: assert property (@(posedge clock) $fell(reset) |-> empty)
  else
  begin
    failure_count = failure_count + 1;
    $error("FIFO not empty after reset");
  end

endmodule

bind line_fifo capture_assert u_assert (
  .clock (clock),
  .reset (reset),
  .rd    (rd),
  .empty (empty),
  .full  (full)
);

// ==== capture_top.sv ====
`timescale 1ns/1ps

module capture_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              capture_enable,  // frames run while high
  input  pixel_pkg::pixel_t pattern_base,  // test-pattern offset
  input  logic              drain_enable,  // packer reads while high
  output pixel_pkg::byte_t  pixel_byte,
  output logic              byte_valid,
  output logic              frame_done,
  output logic              overflow,
  output logic              fifo_empty
);
  import pixel_pkg::*;

  video_beat_t beat;  // producer to FIFO bus
  logic        frame_start;
  logic        rd;
  pixel_t      dout;
  logic        overflow_pulse;

  // producer, href/vsync timing and pattern pixels
  sync_timing_gen u_timing (
    .clock          (clock),
    .reset          (reset),
    .capture_enable (capture_enable),
    .pattern_base   (pattern_base),
    .beat           (beat),
    .frame_start    (frame_start),
    .frame_done     (frame_done)
  );

  // buffer between the line timing and the drain
  line_fifo u_fifo (
    .clock          (clock),
    .reset          (reset),
    .beat           (beat),
    .rd             (rd),
    .dout           (dout),
    .empty          (fifo_empty),
    .full           (),  // only the FIFO itself and its bound checks look at full
    .overflow_pulse (overflow_pulse)
  );

  // consumer, four pixels into one byte
  pixel_packer u_packer (
    .clock          (clock),
    .reset          (reset),
    .drain_enable   (drain_enable),
    .empty          (fifo_empty),
    .dout           (dout),
    .overflow_pulse (overflow_pulse),
    .frame_start    (frame_start),
    .rd             (rd),
    .pixel_byte     (pixel_byte),
    .byte_valid     (byte_valid),
    .overflow       (overflow)
  );

endmodule

// ==== pixel_packer.sv ====
`timescale 1ns/1ps

module pixel_packer (
  input  logic              clock,
  input  logic              reset,
  input  logic              drain_enable,  // level, reads allowed while high
  input  logic              empty,  // FIFO flag, used only to form rd
  input  pixel_pkg::pixel_t dout,  // FIFO data, valid the clock after rd
  input  logic              overflow_pulse,  // pixel dropped at the FIFO
  input  logic              frame_start,  // clears the sticky overflow
  output logic              rd,
  output pixel_pkg::byte_t  pixel_byte,
  output logic              byte_valid,  // one clock per finished byte
  output logic              overflow  // sticky until the next frame_start
);
  import pixel_pkg::*;

  logic       dout_valid;  // rd delayed by one clock
  logic [1:0] slot_q;  // pixels already collected in the current byte
  byte_t      shift_q;  // new pixels enter at the top
  logic       last_slot;

  assign rd = drain_enable & ~empty;
  assign last_slot = (slot_q == 2'(PIXELS_PER_BYTE - 1));
  assign pixel_byte = shift_q;  // holds all four pixels while byte_valid is high

  // after four shifts the first pixel sits in bits 1:0
  always_ff @(posedge clock)
  begin
    if (dout_valid)
      shift_q <= {dout, shift_q[$bits(byte_t)-1:$bits(pixel_t)]};
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      dout_valid <= 1'b0;
      slot_q <= '0;
      byte_valid <= 1'b0;
      overflow <= 1'b0;
    end
    else
    begin
      dout_valid <= rd;
      byte_valid <= dout_valid & last_slot;  // fourth pixel shifted in this clock
      if (dout_valid)
        slot_q <= slot_q + 2'd1;  // wraps back to slot 0
      if (frame_start)
        overflow <= 1'b0;
      if (overflow_pulse)
        overflow <= 1'b1;  // set wins over a clear in the same clock
    end
  end

endmodule

// ==== line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo (
  input  logic                   clock,
  input  logic                   reset,
  input  pixel_pkg::video_beat_t beat,  // pixels written while href and not vsync
  input  logic                   rd,  // read strobe from the packer
  output pixel_pkg::pixel_t      dout,  // valid the clock after rd
  output logic                   empty,
  output logic                   full,
  output logic                   overflow_pulse  // one clock per dropped pixel
);
  import pixel_pkg::*;

  pixel_t      mem [FIFO_DEPTH];  // line storage
  fifo_addr_t  wr_ptr;  // next slot to write
  fifo_addr_t  rd_ptr;  // next slot to read
  fifo_count_t count;  // occupancy, 0..FIFO_DEPTH
  logic        wr;  // write attempt from the bus
  logic        wr_en;  // write accepted
  logic        rd_en;  // read accepted

  assign wr = beat.href & ~beat.vsync;  // same gating as the sensor bus
  assign wr_en = wr & ~full;  // pixel dropped when full
  assign rd_en = rd & ~empty;  // guard, packer already avoids this

  // flags straight from the occupancy count
  assign full = (count == fifo_count_t'(FIFO_DEPTH));
  assign empty = (count == '0);

  always_ff @(posedge clock)
  begin
    if (wr_en)
      mem[wr_ptr] <= beat.pix;
  end

  always_ff @(posedge clock)
  begin
    if (rd_en)
      dout <= mem[rd_ptr];  // output register moves only on a read
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow_pulse <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + fifo_addr_t'(1);  // wraps at FIFO_DEPTH
      if (rd_en)
        rd_ptr <= rd_ptr + fifo_addr_t'(1);
      case ({wr_en, rd_en})
        2'b10: count <= count + fifo_count_t'(1);  // write only
        2'b01: count <= count - fifo_count_t'(1);  // read only
        default: count <= count;  // idle, or read and write together
      endcase
      overflow_pulse <= wr & full;  // write attempt found no room
    end
  end

endmodule

// ==== sync_timing_gen.sv ====
`timescale 1ns/1ps

module sync_timing_gen (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   capture_enable,  // start frames while high
  input  pixel_pkg::pixel_t      pattern_base,  // offset added to every pixel
  output pixel_pkg::video_beat_t beat,  // registered bus beat
  output logic                   frame_start,  // pulse on entry to V_BLANK
  output logic                   frame_done  // pulse on the last clock of a frame
);
  import capture_timing_pkg::*;
  import pixel_pkg::*;

  timing_state_t state_q;
  timing_state_t state_d;
  column_t       column_q;
  column_t       column_d;
  line_t         line_q;
  line_t         line_d;
  line_t         active_line;  // line index counted from the first active line
  video_beat_t   beat_d;
  logic          last_column;
  logic          last_line;

  assign last_column = (column_q == column_t'(LINE_PERIOD - 1));
  assign last_line = (line_q == line_t'(LAST_LINE));

  // next position and phase of the frame
  always_comb
  begin
    state_d = state_q;
    column_d = column_q + column_t'(1);  // default is one step along the line
    line_d = line_q;
    case (state_q)
      IDLE:
      begin
        column_d = '0;
        line_d = '0;
        if (capture_enable)
          state_d = V_BLANK;  // frame begins on the next beat
      end
      V_BLANK:
      begin
        if (last_column)
        begin
          column_d = '0;
          line_d = line_q + line_t'(1);
          if (line_q == line_t'(V_BLANK_LINES - 1))
            state_d = LINE_ACTIVE;  // blanking over, first active line
        end
      end
      LINE_ACTIVE:
      begin
        if (column_q == column_t'(ACTIVE_PIXELS - 1))
          state_d = LINE_BLANK;  // last pixel of the line
      end
      LINE_BLANK:
      begin
        if (last_column)
        begin
          column_d = '0;
          line_d = line_q + line_t'(1);
          state_d = LINE_ACTIVE;
          if (last_line)
          begin
            line_d = '0;
            state_d = capture_enable ? V_BLANK : IDLE;  // back-to-back or stop
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign active_line = line_d - line_t'(V_BLANK_LINES);  // wraps in blanking, unused there

  // beat for the position just computed, pattern is (c + l + base) mod 4
  always_comb
  begin
    beat_d.href = (state_d == LINE_ACTIVE);
    beat_d.vsync = (state_d == IDLE) || (state_d == V_BLANK);
    beat_d.pix = '0;
    if (beat_d.href)
      beat_d.pix = pixel_t'(column_d) + pixel_t'(active_line) + pattern_base;
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state_q <= IDLE;
      column_q <= '0;
      line_q <= '0;
      beat <= '{href: 1'b0, vsync: 1'b1, pix: '0};  // bus idles in blanking
      frame_start <= 1'b0;
      frame_done <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      column_q <= column_d;
      line_q <= line_d;
      beat <= beat_d;
      frame_start <= (state_d == V_BLANK) && (state_q != V_BLANK);
      frame_done <= (state_d == LINE_BLANK) && (column_d == column_t'(LINE_PERIOD - 1))
                    && (line_d == line_t'(LAST_LINE));  // aligned with the final beat
    end
  end

endmodule

// ==== pixel_pkg.sv ====
package pixel_pkg;

  // one sensor pixel, two bits wide
  typedef logic [1:0] pixel_t;

  // packed output, four pixels per byte
  typedef logic [7:0] byte_t;

  localparam int PIXELS_PER_BYTE = 4;  // first pixel lands in the low bits

  // line FIFO geometry
  localparam int FIFO_ABITS = 4;  // address bits
  localparam int FIFO_DEPTH = 1 << FIFO_ABITS;  // 16 entries, all usable

  typedef logic [FIFO_ABITS-1:0] fifo_addr_t;  // read and write pointers
  typedef logic [FIFO_ABITS:0] fifo_count_t;  // occupancy, 0..FIFO_DEPTH

  // one clock of the camera-style bus
  typedef struct packed {
    logic href;  // high while a line carries pixels
    logic vsync;  // high during vertical blanking
    pixel_t pix;  // pixel value, only meaningful with href
  } video_beat_t;

endpackage

// ==== capture_timing_pkg.sv ====
package capture_timing_pkg;

  // frame geometry in clocks and lines
  localparam int ACTIVE_PIXELS = 16;  // pixels per active line
  localparam int H_BLANK = 4;  // blank clocks after each line
  localparam int ACTIVE_LINES = 4;  // active lines per frame
  localparam int V_BLANK_LINES = 2;  // line periods with vsync high

  localparam int LINE_PERIOD = ACTIVE_PIXELS + H_BLANK;  // clocks per line
  localparam int FRAME_LINES = V_BLANK_LINES + ACTIVE_LINES;  // lines per frame
  localparam int LAST_LINE = FRAME_LINES - 1;  // index of the final active line
  localparam int FRAME_CLOCKS = FRAME_LINES * LINE_PERIOD;  // clocks per frame

  localparam int COLUMN_BITS = $clog2(LINE_PERIOD);  // 5 bits for 0..19
  localparam int LINE_BITS = $clog2(FRAME_LINES);  // 3 bits for 0..5

  // column inside one line period, active and blank
  typedef logic [COLUMN_BITS-1:0] column_t;

  // line inside one frame, blanking lines first
  typedef logic [LINE_BITS-1:0] line_t;

  // generator phases
  typedef enum logic [1:0] {
    IDLE,  // waiting for capture_enable, vsync held high
    V_BLANK,  // vertical blanking, vsync high
    LINE_ACTIVE,  // href high, pixels on the bus
    LINE_BLANK  // horizontal blanking, href low
  } timing_state_t;

endpackage
